// ==== dma_write.f ====
+incdir+source
source/dma_write_pkg.sv
source/dma_sync_fifo.sv
source/dma_write_regs.sv
source/dma_wlast_gen.sv
source/dma_write.sv
verification/tb_dma_write.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# verilator build and run of the dma_write testbench

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_dma_write \
    -f dma_write.f -o tb_dma_write > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_dma_write > sim.log 2>&1
cat sim.log
grep -q "TEST FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// ==== source/dma_sync_fifo.sv ====
module dma_sync_fifo #(
    parameter type payload_t = logic,
    parameter int  PTR_BITS  = 3
) (
    input  logic     s_axi4l,
    input  logic     rst,

    input  payload_t s_data,
    input  logic     s_valid,
    output logic     s_ready,

    output payload_t m_data,
    output logic     m_valid,
    input  logic     m_ready
);

    localparam int DEPTH = 1 << PTR_BITS;

    payload_t            mem [0:DEPTH-1];
    logic [PTR_BITS:0]   wr_ptr;
    logic [PTR_BITS:0]   rd_ptr;
    logic                mem_empty;
    logic                mem_full;
    logic                push;
    logic                load;
    logic                bypass;

    assign mem_empty = (wr_ptr == rd_ptr);
    assign mem_full  = (wr_ptr[PTR_BITS] != rd_ptr[PTR_BITS]) &&
                       (wr_ptr[PTR_BITS-1:0] == rd_ptr[PTR_BITS-1:0]);

    assign s_ready = !mem_full;
    assign push    = s_valid && s_ready;

    // output stage free or being emptied this cycle
    assign load    = !m_valid || m_ready;

    // skip the ram when it is empty and the output stage is free
    assign bypass  = push && mem_empty && load;

    // ------------------------------------------------------------------------
    //  storage
    // ------------------------------------------------------------------------
    always_ff @(posedge s_axi4l) begin
        if (push && !bypass) begin
            mem[wr_ptr[PTR_BITS-1:0]] <= s_data;
        end
    end

    always_ff @(posedge s_axi4l) begin
        if (load) begin
            m_data <= mem_empty ? s_data : mem[rd_ptr[PTR_BITS-1:0]];
        end
    end

    // ------------------------------------------------------------------------
    //  pointers and output valid
    // ------------------------------------------------------------------------
    always_ff @(posedge s_axi4l) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            m_valid <= 1'b0;
        end else begin
            if (push && !bypass) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load) begin
                if (!mem_empty) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                m_valid <= !mem_empty || push;
            end
        end
    end

    // output holds while stalled
    a_hold_stable: assert property (@(posedge s_axi4l) disable iff (rst)
        m_valid && !m_ready |=> $stable(m_data) && m_valid);

endmodule

// ==== source/dma_wlast_gen.sv ====
module dma_wlast_gen (
    input  logic                     s_axi4l,
    input  logic                     rst,

    input  dma_write_pkg::len_t      len,
    input  logic                     len_valid,
    output logic                     len_ready,

    input  dma_write_pkg::data_t     axi4s_tdata,
    input  logic                     axi4s_tvalid,
    output logic                     axi4s_tready,

    output dma_write_pkg::w_beat_t   beat,
    output logic                     beat_valid,
    input  logic                     beat_ready
);

    import dma_write_pkg::*;

    logic   active;
    len_t   remain;
    logic   last;
    logic   accept;

    assign accept = axi4s_tvalid && axi4s_tready;

    // next length taken when idle or on the closing beat
    assign len_ready = !active || (last && accept);

    always_ff @(posedge s_axi4l) begin
        if (rst) begin
            active <= 1'b0;
            remain <= '0;
            last   <= 1'b0;
        end else if (len_ready) begin
            active <= len_valid;
            remain <= len - 1'b1;
            last   <= (len == '0);
        end else if (accept) begin
            remain <= remain - 1'b1;
            last   <= (remain == '0);
        end
    end

    // stream passes only inside a burst
    assign axi4s_tready = beat_ready && active;
    assign beat_valid   = axi4s_tvalid && active;
    assign beat         = '{last: last, data: axi4s_tdata};

    // ready comes up only after a length load or when the data fifo frees
    a_ready_rise: assert property (@(posedge s_axi4l) disable iff (rst)
        $rose(axi4s_tready) |-> $past(len_valid && len_ready) || $rose(beat_ready));

endmodule

// ==== source/dma_write.sv ====
`include "dma_write_settings.svh"

module dma_write (
    input  logic                              s_axi4l,
    input  logic                              rst,

    input  logic [`DMA_AXI4L_ADDR_BITS-1:0]   axi4l_awaddr,
    input  logic                              axi4l_awvalid,
    output logic                              axi4l_awready,
    input  dma_write_pkg::axi4l_data_t        axi4l_wdata,
    input  dma_write_pkg::axi4l_strb_t        axi4l_wstrb,
    input  logic                              axi4l_wvalid,
    output logic                              axi4l_wready,
    output dma_write_pkg::resp_t              axi4l_bresp,
    output logic                              axi4l_bvalid,
    input  logic                              axi4l_bready,
    input  logic [`DMA_AXI4L_ADDR_BITS-1:0]   axi4l_araddr,
    input  logic                              axi4l_arvalid,
    output logic                              axi4l_arready,
    output dma_write_pkg::axi4l_data_t        axi4l_rdata,
    output dma_write_pkg::resp_t              axi4l_rresp,
    output logic                              axi4l_rvalid,
    input  logic                              axi4l_rready,

    input  dma_write_pkg::data_t              axi4s_tdata,
    input  logic                              axi4s_tvalid,
    output logic                              axi4s_tready,

    output dma_write_pkg::id_t                m_awid,
    output dma_write_pkg::addr_t              m_awaddr,
    output dma_write_pkg::len_t               m_awlen,
    output logic                              m_awvalid,
    input  logic                              m_awready,
    output dma_write_pkg::data_t              m_wdata,
    output logic                              m_wlast,
    output logic                              m_wvalid,
    input  logic                              m_wready,
    input  dma_write_pkg::resp_t              m_bresp,
    input  logic                              m_bvalid,
    output logic                              m_bready
);

    import dma_write_pkg::*;

    aw_req_t    req;
    logic       req_valid;
    logic       req_ready;
    aw_req_t    aw_out;

    len_t       len;
    logic       len_valid;
    logic       len_ready;
    len_t       lfifo_len;
    logic       lfifo_valid;
    logic       lfifo_ready;

    w_beat_t    beat;
    logic       beat_valid;
    logic       beat_ready;
    w_beat_t    w_out;

    // ------------------------------------------------------------------------
    //  register block
    // ------------------------------------------------------------------------
    dma_write_regs i_regs (
        .s_axi4l, .rst,
        .axi4l_awaddr, .axi4l_awvalid, .axi4l_awready,
        .axi4l_wdata, .axi4l_wstrb, .axi4l_wvalid, .axi4l_wready,
        .axi4l_bresp, .axi4l_bvalid, .axi4l_bready,
        .axi4l_araddr, .axi4l_arvalid, .axi4l_arready,
        .axi4l_rdata, .axi4l_rresp, .axi4l_rvalid, .axi4l_rready,
        .req, .req_valid, .req_ready,
        .len, .len_valid, .len_ready,
        .m_bresp, .m_bvalid, .m_bready
    );

    // ------------------------------------------------------------------------
    //  request, length and data paths
    // ------------------------------------------------------------------------
    dma_sync_fifo #(.payload_t(aw_req_t), .PTR_BITS(`DMA_AWFIFO_PTR_BITS)) i_aw_fifo (
        .s_axi4l, .rst,
        .s_data(req), .s_valid(req_valid), .s_ready(req_ready),
        .m_data(aw_out), .m_valid(m_awvalid), .m_ready(m_awready)
    );

    dma_sync_fifo #(.payload_t(len_t), .PTR_BITS(`DMA_AWFIFO_PTR_BITS)) i_len_fifo (
        .s_axi4l, .rst,
        .s_data(len), .s_valid(len_valid), .s_ready(len_ready),
        .m_data(lfifo_len), .m_valid(lfifo_valid), .m_ready(lfifo_ready)
    );

    dma_wlast_gen i_wlast_gen (
        .s_axi4l, .rst,
        .len(lfifo_len), .len_valid(lfifo_valid), .len_ready(lfifo_ready),
        .axi4s_tdata, .axi4s_tvalid, .axi4s_tready,
        .beat, .beat_valid, .beat_ready
    );

    dma_sync_fifo #(.payload_t(w_beat_t), .PTR_BITS(`DMA_WFIFO_PTR_BITS)) i_w_fifo (
        .s_axi4l, .rst,
        .s_data(beat), .s_valid(beat_valid), .s_ready(beat_ready),
        .m_data(w_out), .m_valid(m_wvalid), .m_ready(m_wready)
    );

    assign m_awid   = aw_out.id;
    assign m_awaddr = aw_out.addr;
    assign m_awlen  = aw_out.len;
    assign m_wdata  = w_out.data;
    assign m_wlast  = w_out.last;

endmodule

// ==== source/dma_write_pkg.sv ====
`include "dma_write_settings.svh"

package dma_write_pkg;

    // ------------------------------------------------------------------------
    //  scalar types
    // ------------------------------------------------------------------------
    typedef logic [`DMA_ID_BITS-1:0]            id_t;
    typedef logic [`DMA_ADDR_BITS-1:0]          addr_t;
    typedef logic [`DMA_LEN_BITS-1:0]           len_t;
    typedef logic [`DMA_DATA_BITS-1:0]          data_t;
    typedef logic [`DMA_RESP_BITS-1:0]          resp_t;
    typedef logic [`DMA_ISSUE_CNT_BITS-1:0]     issue_cnt_t;

    // register word index
    typedef logic [5:0]                         regadr_t;

    typedef logic [`DMA_AXI4L_DATA_BITS-1:0]    axi4l_data_t;
    typedef logic [`DMA_AXI4L_DATA_BITS/8-1:0]  axi4l_strb_t;

    // ------------------------------------------------------------------------
    //  fifo payloads
    // ------------------------------------------------------------------------
    typedef struct packed {
        id_t    id;
        addr_t  addr;
        len_t   len;
    } aw_req_t;

    typedef struct packed {
        logic   last;
        data_t  data;
    } w_beat_t;

endpackage

// ==== source/dma_write_regs.sv ====
`include "dma_write_settings.svh"

module dma_write_regs (
    input  logic                              s_axi4l,
    input  logic                              rst,

    input  logic [`DMA_AXI4L_ADDR_BITS-1:0]   axi4l_awaddr,
    input  logic                              axi4l_awvalid,
    output logic                              axi4l_awready,
    input  dma_write_pkg::axi4l_data_t        axi4l_wdata,
    input  dma_write_pkg::axi4l_strb_t        axi4l_wstrb,
    input  logic                              axi4l_wvalid,
    output logic                              axi4l_wready,
    output dma_write_pkg::resp_t              axi4l_bresp,
    output logic                              axi4l_bvalid,
    input  logic                              axi4l_bready,
    input  logic [`DMA_AXI4L_ADDR_BITS-1:0]   axi4l_araddr,
    input  logic                              axi4l_arvalid,
    output logic                              axi4l_arready,
    output dma_write_pkg::axi4l_data_t        axi4l_rdata,
    output dma_write_pkg::resp_t              axi4l_rresp,
    output logic                              axi4l_rvalid,
    input  logic                              axi4l_rready,

    output dma_write_pkg::aw_req_t            req,
    output logic                              req_valid,
    input  logic                              req_ready,

    output dma_write_pkg::len_t               len,
    output logic                              len_valid,
    input  logic                              len_ready,

    input  dma_write_pkg::resp_t              m_bresp,
    input  logic                              m_bvalid,
    output logic                              m_bready
);

    import dma_write_pkg::*;

    id_t          reg_awid;
    addr_t        reg_awaddr;
    len_t         reg_awlen;
    logic         aw_pending;
    logic         len_pending;
    logic         resp_error;
    issue_cnt_t   issue_cnt;
    issue_cnt_t   issue_cnt_next;

    regadr_t      regadr_wr;
    regadr_t      regadr_rd;
    logic         wr_en;
    logic         rd_en;
    logic         launch;
    logic         resp_accept;

    // merge new data into old value by byte lane
    function automatic axi4l_data_t write_mask(
        input axi4l_data_t org,
        input axi4l_data_t data,
        input axi4l_strb_t strb
    );
        axi4l_data_t result;
        for (int i = 0; i < $bits(axi4l_data_t); i++) begin
            result[i] = strb[i/8] ? data[i] : org[i];
        end
        return result;
    endfunction

    // ------------------------------------------------------------------------
    //  write channel
    // ------------------------------------------------------------------------
    assign regadr_wr = regadr_t'(axi4l_awaddr >> 2);
    assign regadr_rd = regadr_t'(axi4l_araddr >> 2);

    // address and data are taken together
    assign axi4l_awready = axi4l_awvalid && axi4l_wvalid && (!axi4l_bvalid || axi4l_bready);
    assign axi4l_wready  = axi4l_awready;
    assign axi4l_bresp   = '0;

    assign wr_en  = axi4l_awvalid && axi4l_awready;
    assign launch = wr_en && (regadr_wr == `DMA_REG_AWADDR);

    always_ff @(posedge s_axi4l) begin
        if (rst) begin
            axi4l_bvalid <= 1'b0;
        end else if (wr_en) begin
            axi4l_bvalid <= 1'b1;
        end else if (axi4l_bready) begin
            axi4l_bvalid <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    //  register file and request launch
    // ------------------------------------------------------------------------
    assign resp_accept    = m_bvalid && m_bready;
    assign issue_cnt_next = issue_cnt + issue_cnt_t'(launch) - issue_cnt_t'(resp_accept);

    always_ff @(posedge s_axi4l) begin
        if (rst) begin
            reg_awid    <= '0;
            reg_awaddr  <= '0;
            reg_awlen   <= '0;
            aw_pending  <= 1'b0;
            len_pending <= 1'b0;
            resp_error  <= 1'b0;
            issue_cnt   <= '0;
        end else begin
            if (req_valid && req_ready) begin
                aw_pending <= 1'b0;
            end
            if (len_valid && len_ready) begin
                len_pending <= 1'b0;
            end

            if (wr_en) begin
                case (regadr_wr)
                    `DMA_REG_STATUS: begin
                        resp_error <= 1'b0;
                    end
                    `DMA_REG_AWID: begin
                        reg_awid <= id_t'(write_mask(axi4l_data_t'(reg_awid),
                                                     axi4l_wdata, axi4l_wstrb));
                    end
                    `DMA_REG_AWADDR: begin
                        reg_awaddr  <= addr_t'(write_mask(axi4l_data_t'(reg_awaddr),
                                                          axi4l_wdata, axi4l_wstrb));
                        aw_pending  <= 1'b1;
                        len_pending <= 1'b1;
                    end
                    `DMA_REG_AWLEN: begin
                        reg_awlen <= len_t'(write_mask(axi4l_data_t'(reg_awlen),
                                                       axi4l_wdata, axi4l_wstrb));
                    end
                    default: ;
                endcase
            end

            // error set wins over a clear in the same cycle
            if (resp_accept && m_bresp != '0) begin
                resp_error <= 1'b1;
            end

            issue_cnt <= issue_cnt_next;
        end
    end

    assign req       = '{id: reg_awid, addr: reg_awaddr, len: reg_awlen};
    assign req_valid = aw_pending;
    assign len       = reg_awlen;
    assign len_valid = len_pending;
    assign m_bready  = (issue_cnt != '0);

    // ------------------------------------------------------------------------
    //  read channel
    // ------------------------------------------------------------------------
    assign axi4l_arready = !axi4l_rvalid || axi4l_rready;
    assign axi4l_rresp   = '0;
    assign rd_en         = axi4l_arvalid && axi4l_arready;

    always_ff @(posedge s_axi4l) begin
        if (rd_en) begin
            case (regadr_rd)
                `DMA_REG_CORE_ID:   axi4l_rdata <= `DMA_CORE_ID_VALUE;
                `DMA_REG_STATUS:    axi4l_rdata <= axi4l_data_t'({resp_error, len_pending,
                                                                  aw_pending});
                `DMA_REG_ISSUE_CNT: axi4l_rdata <= axi4l_data_t'(issue_cnt);
                `DMA_REG_AWID:      axi4l_rdata <= axi4l_data_t'(reg_awid);
                `DMA_REG_AWADDR:    axi4l_rdata <= axi4l_data_t'(reg_awaddr);
                `DMA_REG_AWLEN:     axi4l_rdata <= axi4l_data_t'(reg_awlen);
                default:            axi4l_rdata <= '0;
            endcase
        end
    end

    always_ff @(posedge s_axi4l) begin
        if (rst) begin
            axi4l_rvalid <= 1'b0;
        end else if (rd_en) begin
            axi4l_rvalid <= 1'b1;
        end else if (axi4l_rready) begin
            axi4l_rvalid <= 1'b0;
        end
    end

    // a response only arrives while a request is outstanding
    a_no_underflow: assert property (@(posedge s_axi4l) disable iff (rst)
        m_bvalid |-> issue_cnt != '0);

endmodule

// ==== source/dma_write_settings.svh ====
`ifndef DMA_WRITE_SETTINGS_SVH
`define DMA_WRITE_SETTINGS_SVH

// bus widths
`define DMA_AXI4L_ADDR_BITS     8
`define DMA_AXI4L_DATA_BITS     32
`define DMA_ID_BITS             4
`define DMA_ADDR_BITS           32
`define DMA_LEN_BITS            8
`define DMA_DATA_BITS           64
`define DMA_RESP_BITS           2
`define DMA_ISSUE_CNT_BITS      8

// fifo depth as log2
`define DMA_AWFIFO_PTR_BITS     3
`define DMA_WFIFO_PTR_BITS      4

// register map in word offsets
`define DMA_REG_CORE_ID         6'h00
`define DMA_REG_STATUS          6'h08
`define DMA_REG_ISSUE_CNT       6'h09
`define DMA_REG_AWID            6'h10
`define DMA_REG_AWADDR          6'h11
`define DMA_REG_AWLEN           6'h12
`define DMA_CORE_ID_VALUE       32'hd3a0_0101

`endif

// ==== verification/tb_dma_write.sv ====
`include "dma_write_settings.svh"

module tb_dma_write;

    import dma_write_pkg::*;

    typedef struct packed {
        id_t    id;
        addr_t  addr;
        len_t   len;
        resp_t  bresp;
    } row_t;

    localparam int ROWS = 6;

    // id, address, length minus one, response from the slave model
    row_t xfer_rows [ROWS] = '{
        {4'h3, 32'h0000_1000, 8'd0,  2'd0},
        {4'ha, 32'h0000_2040, 8'd3,  2'd0},
        {4'h5, 32'h8000_0100, 8'd7,  2'd0},
        {4'hc, 32'h0001_0000, 8'd1,  2'd2},
        {4'h1, 32'h0002_0200, 8'd15, 2'd0},
        {4'hf, 32'hffff_f000, 8'd4,  2'd0}
    };

    logic s_axi4l;
    logic rst;
    logic [`DMA_AXI4L_ADDR_BITS-1:0] axi4l_awaddr;
    logic [`DMA_AXI4L_ADDR_BITS-1:0] axi4l_araddr;
    logic axi4l_awvalid, axi4l_awready, axi4l_wvalid, axi4l_wready;
    logic axi4l_bvalid, axi4l_bready, axi4l_arvalid, axi4l_arready;
    logic axi4l_rvalid, axi4l_rready;
    axi4l_data_t axi4l_wdata;
    axi4l_data_t axi4l_rdata;
    axi4l_strb_t axi4l_wstrb;
    resp_t axi4l_bresp;
    resp_t axi4l_rresp;
    data_t axi4s_tdata;
    logic axi4s_tvalid, axi4s_tready;
    id_t m_awid;
    addr_t m_awaddr;
    len_t m_awlen;
    logic m_awvalid, m_awready;
    data_t m_wdata;
    logic m_wlast, m_wvalid, m_wready;
    resp_t m_bresp;
    logic m_bvalid, m_bready;

    logic [31:0] lfsr_state = 32'hc17f_4a88;
    logic        stream_go = 1'b0;
    int          resp_sent = 0;
    int          bursts_done = 0;
    aw_req_t     aw_seen [$];
    w_beat_t     w_seen [$];
    data_t       stream_sent [$];

    dma_write i_dma_write (.*);

    initial begin
        s_axi4l = 1'b0;
        forever #10 s_axi4l = !s_axi4l;
    end

    // ------------------------------------------------------------------------
    //  helpers
    // ------------------------------------------------------------------------
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] lfsr_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic expect_equal(input string what, input logic [63:0] got,
                                input logic [63:0] want);
        if (got !== want) begin
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, what, got, want);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic reg_write(input regadr_t offset, input axi4l_data_t data,
                             input axi4l_strb_t strb);
        @(negedge s_axi4l);
        axi4l_awaddr  = {offset, 2'b00};
        axi4l_wdata   = data;
        axi4l_wstrb   = strb;
        axi4l_awvalid = 1'b1;
        axi4l_wvalid  = 1'b1;
        #1;
        while (!axi4l_awready) begin
            @(negedge s_axi4l);
            #1;
        end
        expect_equal("axi4l wready", axi4l_wready, 1);
        @(negedge s_axi4l);
        axi4l_awvalid = 1'b0;
        axi4l_wvalid  = 1'b0;
        #1;
        while (!axi4l_bvalid) begin
            @(negedge s_axi4l);
            #1;
        end
        expect_equal("axi4l bresp", axi4l_bresp, 0);
    endtask

    task automatic reg_read(input regadr_t offset, output axi4l_data_t data);
        @(negedge s_axi4l);
        axi4l_araddr  = {offset, 2'b00};
        axi4l_arvalid = 1'b1;
        #1;
        while (!axi4l_arready) begin
            @(negedge s_axi4l);
            #1;
        end
        @(negedge s_axi4l);
        axi4l_arvalid = 1'b0;
        #1;
        while (!axi4l_rvalid) begin
            @(negedge s_axi4l);
            #1;
        end
        data = axi4l_rdata;
        expect_equal("axi4l rresp", axi4l_rresp, 0);
    endtask

    // poll status until both pending bits are gone
    task automatic wait_launch_done();
        axi4l_data_t st;
        st = '1;
        while (st[1:0] != 2'b00) begin
            reg_read(`DMA_REG_STATUS, st);
        end
    endtask

    // ------------------------------------------------------------------------
    //  stream source holding each beat until taken
    // ------------------------------------------------------------------------
    initial begin
        int   total;
        int   sent;
        logic took;
        total = 0;
        sent = 0;
        took = 1'b0;
        axi4s_tvalid = 1'b0;
        axi4s_tdata = '0;
        foreach (xfer_rows[r]) begin
            total += int'(xfer_rows[r].len) + 1;
        end
        wait (stream_go);
        forever begin
            @(negedge s_axi4l);
            if (!axi4s_tvalid || took) begin
                axi4s_tvalid = (sent < total) && (lfsr_bits(2) != 0);
                if (axi4s_tvalid) begin
                    axi4s_tdata = lfsr_bits(64);
                end
            end
            #1;
            took = axi4s_tvalid && axi4s_tready;
            if (took) begin
                stream_sent.push_back(axi4s_tdata);
                sent++;
            end
        end
    end

    // ------------------------------------------------------------------------
    //  axi4 slave model
    // ------------------------------------------------------------------------
    initial begin
        logic b_took;
        b_took = 1'b0;
        m_awready = 1'b0;
        m_wready = 1'b0;
        m_bvalid = 1'b0;
        m_bresp = '0;
        forever begin
            @(negedge s_axi4l);
            // aw held off until the first rows are queued
            m_awready = stream_go && lfsr_bit();
            m_wready = (lfsr_bits(2) != 0);
            if (b_took) begin
                m_bvalid = 1'b0;
                resp_sent++;
            end
            if (!m_bvalid && resp_sent < aw_seen.size() && resp_sent < bursts_done) begin
                m_bvalid = 1'b1;
                m_bresp = xfer_rows[resp_sent].bresp;
            end
            #1;
            if (m_awvalid && m_awready) begin
                aw_seen.push_back({m_awid, m_awaddr, m_awlen});
            end
            if (m_wvalid && m_wready) begin
                w_seen.push_back({m_wlast, m_wdata});
                if (m_wlast) begin
                    bursts_done++;
                end
            end
            b_took = m_bvalid && m_bready;
        end
    end

    initial begin
        int max_beats;
        int limit;
        max_beats = 0;
        foreach (xfer_rows[r]) begin
            if (int'(xfer_rows[r].len) + 1 > max_beats) begin
                max_beats = int'(xfer_rows[r].len) + 1;
            end
        end
        limit = ROWS * max_beats * 40 + 2000;
        repeat (limit) @(posedge s_axi4l);
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        $display("TEST FAIL");
        $fatal(1);
    end

    // ------------------------------------------------------------------------
    //  main sequence
    // ------------------------------------------------------------------------
    initial begin
        axi4l_data_t rd;
        int          idx;
        regadr_t     zero_regs [6];
        zero_regs = '{`DMA_REG_STATUS, `DMA_REG_ISSUE_CNT, `DMA_REG_AWID,
                      `DMA_REG_AWADDR, `DMA_REG_AWLEN, 6'h3f};
        rst = 1'b1;
        axi4l_awaddr = '0;
        axi4l_awvalid = 1'b0;
        axi4l_wdata = '0;
        axi4l_wstrb = '0;
        axi4l_wvalid = 1'b0;
        axi4l_bready = 1'b1;
        axi4l_araddr = '0;
        axi4l_arvalid = 1'b0;
        axi4l_rready = 1'b1;
        repeat (16) @(posedge s_axi4l);
        @(negedge s_axi4l);
        rst = 1'b0;

        expect_equal("axi4l bvalid after reset", axi4l_bvalid, 0);
        expect_equal("axi4l rvalid after reset", axi4l_rvalid, 0);
        expect_equal("m_awvalid after reset", m_awvalid, 0);
        expect_equal("m_wvalid after reset", m_wvalid, 0);
        expect_equal("m_bready after reset", m_bready, 0);
        expect_equal("axi4s_tready after reset", axi4s_tready, 0);

        reg_read(`DMA_REG_CORE_ID, rd);
        expect_equal("core id", rd, `DMA_CORE_ID_VALUE);
        foreach (zero_regs[i]) begin
            reg_read(zero_regs[i], rd);
            expect_equal("register after reset", rd, 0);
        end

        // only byte 0 carries awid and awlen
        reg_write(`DMA_REG_AWID, 32'hffff_fff5, 4'b0000);
        reg_read(`DMA_REG_AWID, rd);
        expect_equal("awid, no strobe", rd, 0);
        reg_write(`DMA_REG_AWID, 32'h0000_000b, 4'b0001);
        reg_write(`DMA_REG_AWID, 32'h0000_0006, 4'b1110);
        reg_read(`DMA_REG_AWID, rd);
        expect_equal("awid, masked", rd, 32'hb);
        reg_write(`DMA_REG_AWLEN, 32'h0000_00a5, 4'b0001);
        reg_write(`DMA_REG_AWLEN, 32'h0000_7f3c, 4'b1110);
        reg_read(`DMA_REG_AWLEN, rd);
        expect_equal("awlen, masked", rd, 32'ha5);

        foreach (xfer_rows[r]) begin
            if (r == 3) begin
                reg_read(`DMA_REG_ISSUE_CNT, rd);
                expect_equal("issue count before stream", rd, 3);
                stream_go = 1'b1;
            end
            reg_write(`DMA_REG_AWID, 32'(xfer_rows[r].id), 4'hf);
            reg_write(`DMA_REG_AWLEN, 32'(xfer_rows[r].len), 4'hf);
            reg_write(`DMA_REG_AWADDR, xfer_rows[r].addr, 4'hf);
            wait_launch_done();
        end
        wait (resp_sent == ROWS);

        reg_read(`DMA_REG_ISSUE_CNT, rd);
        expect_equal("issue count at end", rd, 0);
        expect_equal("m_bready when idle", m_bready, 0);
        reg_read(`DMA_REG_STATUS, rd);
        expect_equal("status with sticky error", rd, 32'h4);
        reg_write(`DMA_REG_STATUS, 32'h0, 4'hf);
        reg_read(`DMA_REG_STATUS, rd);
        expect_equal("status after clear", rd, 0);

        expect_equal("aw count", 64'(aw_seen.size()), ROWS);
        expect_equal("w count", 64'(w_seen.size()), 64'(stream_sent.size()));
        idx = 0;
        foreach (xfer_rows[r]) begin
            expect_equal("awid", aw_seen[r].id, xfer_rows[r].id);
            expect_equal("awaddr", aw_seen[r].addr, xfer_rows[r].addr);
            expect_equal("awlen", aw_seen[r].len, xfer_rows[r].len);
            for (int k = 0; k <= int'(xfer_rows[r].len); k++) begin
                expect_equal("wdata", w_seen[idx].data, stream_sent[idx]);
                expect_equal("wlast", w_seen[idx].last, 64'(k == int'(xfer_rows[r].len)));
                idx++;
            end
        end
        expect_equal("beats checked", 64'(idx), 64'(w_seen.size()));
        $display("TEST PASS");
        $finish;
    end

endmodule
